//--- dv/idControlTb.sv
`timescale 1ns/1ns

module idControlTb import decodePkg::*; ();
	localparam int NUM_VECTORS = 600;
	localparam int RESET_CYCLES = 4;
	localparam int CYCLE_LIMIT = NUM_VECTORS * 4 / 3; // Run needs about 605 cycles
	localparam logic [5:0] ERET_MARK = 6'h3f; // Marks the ERET table entry

	logic clk = 1'b0;
	logic rst;
	logic [OP_W-1:0] op;
	logic [FUNCT_W-1:0] funct;
	logic [REG_W-1:0] rs;
	logic [REG_W-1:0] rt;
	logic [1:0] cmpSign;
	logic [EXC_W-1:0] prevExcCode;
	logic cmpEq;
	logic prevException;
	logic ifFlush;
	aluOpE aluOp;
	extOpE extOp;
	mulDivOpE mulDivOp;
	hiloWrSelE hiloWrSel;
	memSizeE dmSize;
	destSelE destSel;
	wbSrcE wbSrc;
	npcOpE npcOp;
	logic [EXC_W-1:0] excCode;
	logic shamtSel, mulDivStart, hiloWr, hiloRdHi, hiloAccess;
	logic dmRd, dmWr, rfWr, aluSrcImm, cp0Rd;
	logic isBranch, branchOrJr, exception, eretFlush, cp0Wr;

	logic [11:0] encodings[$]; // {op, funct or rt or rs}
	logic [63:0] knownOps = '0;
	logic shadowExp;
	int checkErrors = 0;
	int cycles = 0;

	idControl u_idControl (.*);

	always #20 clk = ~clk;

	always @(posedge clk) shadowExp <= !rst; // Expected reset shadow

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic buildTable();
		opcodeE o;
		functE f;
		regimmE r;
		o = o.first();
		do begin
			knownOps[o] = 1'b1;
			if (o == OP_SPECIAL) begin
				f = f.first();
				do begin
					encodings.push_back({o, f});
					f = f.next();
				end while (f != f.first());
			end else if (o == OP_REGIMM) begin
				r = r.first();
				do begin
					encodings.push_back({o, 1'b0, r});
					r = r.next();
				end while (r != r.first());
			end else if (o == OP_COP0) begin
				encodings.push_back({o, 1'b0, CP_MFC0});
				encodings.push_back({o, 1'b0, CP_MTC0});
				encodings.push_back({o, ERET_MARK});
			end else
				encodings.push_back({o, 6'd0});
			o = o.next();
		end while (o != o.first());
	endtask

	task automatic applyVector(input bit forceIllegal);
		logic [11:0] enc;
		funct = FUNCT_W'($urandom);
		rs = REG_W'($urandom);
		rt = REG_W'($urandom);
		cmpEq = 1'($urandom);
		cmpSign = 2'($urandom_range(2, 0)); // ZERO, POS or NEG
		prevException = !forceIllegal && ($urandom_range(7, 0) == 0);
		prevExcCode = EXC_W'($urandom);
		ifFlush = !forceIllegal && ($urandom_range(7, 0) == 0);
		if (forceIllegal || $urandom_range(9, 0) == 0) begin
			do begin
				op = OP_W'($urandom);
			end while (knownOps[op]);
		end else begin
			enc = encodings[$urandom_range(encodings.size() - 1, 0)];
			op = enc[11:6];
			if (op == OP_SPECIAL)
				funct = enc[5:0];
			else if (op == OP_REGIMM)
				rt = enc[4:0];
			else if (op == OP_COP0 && enc[5:0] == ERET_MARK) begin
				rs = 5'b10000; // CO form
				funct = FN_ERET;
			end else if (op == OP_COP0) begin
				rs = enc[4:0];
				funct = '0;
			end
		end
	endtask

	function automatic aluOpE aluOpFor();
		case (op)
			OP_ADDI: return ALU_ADD;
			OP_ADDIU: return ALU_ADDU;
			OP_SLTI: return ALU_SLT;
			OP_SLTIU: return ALU_SLTU;
			OP_ANDI: return ALU_AND;
			OP_ORI: return ALU_OR;
			OP_XORI: return ALU_XOR;
			OP_LUI: return ALU_NONE; // Upper immediate skips the ALU
			OP_SPECIAL: ;
			default: return ALU_ADD; // Load and store address
		endcase
		case (funct)
			FN_ADD: return ALU_ADD;
			FN_ADDU: return ALU_ADDU;
			FN_SUB: return ALU_SUB;
			FN_SUBU: return ALU_SUBU;
			FN_AND: return ALU_AND;
			FN_OR: return ALU_OR;
			FN_XOR: return ALU_XOR;
			FN_NOR: return ALU_NOR;
			FN_SLT: return ALU_SLT;
			FN_SLTU: return ALU_SLTU;
			FN_SLL, FN_SLLV: return ALU_SLL;
			FN_SRL, FN_SRLV: return ALU_SRL;
			FN_SRA, FN_SRAV: return ALU_SRA;
			default: return ALU_NONE;
		endcase
	endfunction

	function automatic memSizeE memSizeFor();
		case (op)
			OP_LB: return MEM_LB;
			OP_LBU: return MEM_LBU;
			OP_LH: return MEM_LH;
			OP_LHU: return MEM_LHU;
			OP_SB: return MEM_SB;
			OP_SH: return MEM_SH;
			OP_SW: return MEM_SW;
			default: return MEM_LW;
		endcase
	endfunction

	task automatic checkSignal(input bit ok, input string name);
		assert (ok) else begin
			checkErrors++;
			$display("CHECK FAILED at %0t ns: %s differs from the reference model", $time, name);
		end
	endtask

	task automatic checkOutputs();
		bit isSpec, rAlu, iAlu, isLoad, isStore, linkRegimm, isLink, isJr;
		bit start, isMthi, isMtlo, isMfhi, isMflo, mfc0, isBreak, isSyscall;
		bit isCondBr, taken, expRfWr, expHiloWr, expBrOrJr, legal, expExc;
		npcOpE expNpc;
		wbSrcE expWb;
		mulDivOpE expMd;
		logic [EXC_W-1:0] expCode;
		isSpec = (op == OP_SPECIAL);
		rAlu = isSpec && (funct inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
			FN_XOR, FN_NOR, FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV});
		iAlu = op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
		isLoad = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
		isStore = op inside {OP_SB, OP_SH, OP_SW};
		linkRegimm = (op == OP_REGIMM) && (rt inside {RI_BLTZAL, RI_BGEZAL});
		isLink = (op == OP_JAL) || linkRegimm || (isSpec && funct == FN_JALR);
		isJr = isSpec && (funct inside {FN_JR, FN_JALR});
		start = isSpec && (funct inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU});
		isMthi = isSpec && (funct == FN_MTHI);
		isMtlo = isSpec && (funct == FN_MTLO);
		isMfhi = isSpec && (funct == FN_MFHI);
		isMflo = isSpec && (funct == FN_MFLO);
		mfc0 = (op == OP_COP0) && (rs == CP_MFC0);
		isBreak = isSpec && (funct == FN_BREAK);
		isSyscall = isSpec && (funct == FN_SYSCALL);
		isCondBr = (op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ}) ||
			((op == OP_REGIMM) && (rt inside {RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL}));
		case (op)
			OP_BEQ: taken = cmpEq;
			OP_BNE: taken = !cmpEq;
			OP_BLEZ: taken = (cmpSign != SIGN_POS);
			OP_BGTZ: taken = (cmpSign == SIGN_POS);
			default: taken = (rt inside {RI_BGEZ, RI_BGEZAL}) ?
				(cmpSign != SIGN_NEG) : (cmpSign == SIGN_NEG);
		endcase
		if (isCondBr)
			expNpc = taken ? NPC_BRANCH : NPC_SEQ;
		else if (op == OP_J || op == OP_JAL)
			expNpc = NPC_JUMP;
		else if (isJr)
			expNpc = NPC_REG;
		else
			expNpc = NPC_SEQ;
		if (isLink)
			expWb = WB_LINK;
		else if (isLoad)
			expWb = WB_MEM;
		else if (isMfhi || isMflo)
			expWb = WB_HILO;
		else if (mfc0)
			expWb = WB_CP0;
		else if (op == OP_LUI)
			expWb = WB_IMM_UPPER;
		else
			expWb = WB_ALU;
		case (funct)
			FN_MULT: expMd = MD_MULT;
			FN_DIV: expMd = MD_DIV;
			FN_DIVU: expMd = MD_DIVU;
			default: expMd = MD_MULTU;
		endcase
		expRfWr = rAlu || iAlu || isLoad || isLink || isMfhi || isMflo || mfc0;
		expHiloWr = start || isMthi || isMtlo;
		expBrOrJr = isCondBr || isJr;
		legal = expRfWr || expHiloWr || isStore || isBreak || isSyscall || expBrOrJr ||
			(op inside {OP_COP0, OP_J, OP_JAL});
		expExc = 1'b1;
		if (prevException)
			expCode = prevExcCode; // Earlier stage first
		else if (!legal && !shadowExp && !ifFlush)
			expCode = EXC_RI;
		else if (isBreak)
			expCode = EXC_BP;
		else if (isSyscall)
			expCode = EXC_SYS;
		else begin
			expExc = 1'b0;
			expCode = EXC_NONE;
		end

		if (rAlu || iAlu || isLoad || isStore)
			checkSignal(aluOp == aluOpFor(), "aluOp");
		if (iAlu || isLoad || isStore)
			checkSignal(extOp == ((op == OP_LUI) ? EXT_UPPER :
				((op inside {OP_ANDI, OP_ORI, OP_XORI}) ? EXT_ZERO : EXT_SIGN)), "extOp");
		checkSignal(shamtSel == (isSpec && (funct inside {FN_SLL, FN_SRL, FN_SRA})), "shamtSel");
		checkSignal(aluSrcImm == !isSpec, "aluSrcImm");
		checkSignal(dmRd == isLoad, "dmRd");
		checkSignal(dmWr == isStore, "dmWr");
		if (isLoad || isStore)
			checkSignal(dmSize == memSizeFor(), "dmSize");
		checkSignal(rfWr == expRfWr, "rfWr");
		if (expRfWr) begin
			checkSignal(destSel == ((op == OP_JAL || linkRegimm) ? DEST_RA :
				(isSpec ? DEST_RD : DEST_RT)), "destSel");
			checkSignal(wbSrc == expWb, "wbSrc");
		end
		checkSignal(isBranch == (expBrOrJr || op == OP_J || op == OP_JAL), "isBranch");
		checkSignal(branchOrJr == expBrOrJr, "branchOrJr");
		checkSignal(npcOp == expNpc, "npcOp");
		checkSignal(mulDivStart == start, "mulDivStart");
		if (start)
			checkSignal(mulDivOp == expMd, "mulDivOp");
		checkSignal(hiloWr == expHiloWr, "hiloWr");
		if (expHiloWr)
			checkSignal(hiloWrSel == (start ? HILO_BOTH : (isMthi ? HILO_HI : HILO_LO)),
				"hiloWrSel");
		checkSignal(hiloRdHi == isMfhi, "hiloRdHi");
		checkSignal(hiloAccess == (expHiloWr || isMfhi || isMflo), "hiloAccess");
		checkSignal(exception == expExc, "exception");
		checkSignal(excCode == expCode, "excCode");
		checkSignal(eretFlush == ((op == OP_COP0) && (funct == FN_ERET)), "eretFlush");
		checkSignal(cp0Wr == ((op == OP_COP0) && (rs == CP_MTC0)), "cp0Wr");
		checkSignal(cp0Rd == mfc0, "cp0Rd");
	endtask

	initial begin
		void'($urandom(70));
		rst = 1'b0;
		op = '0; // SLL while in reset
		funct = '0;
		rs = '0;
		rt = '0;
		cmpEq = 1'b0;
		cmpSign = '0;
		prevException = 1'b0;
		prevExcCode = '0;
		ifFlush = 1'b0;
		buildTable();
		repeat (RESET_CYCLES) @(posedge clk);
		for (int i = 0; i < NUM_VECTORS; i++) begin
			#5;
			rst = 1'b1;
			applyVector(i == 0); // First vector lands in the reset shadow
			#25;
			checkOutputs();
			@(posedge clk);
		end
		$display("Errors: %0d check failures, %0d assertion failures", checkErrors,
			u_idControl.u_idControlAsserts.failCount);
		if (checkErrors == 0 && u_idControl.u_idControlAsserts.failCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end
endmodule

//--- dv/idControl_asserts.sv
`timescale 1ns/1ns

module idControl_asserts (
	input logic clk,
	input logic rst,
	input logic dmRd,
	input logic dmWr,
	input logic isBranch,
	input logic branchOrJr,
	input logic mulDivStart,
	input logic hiloWr,
	input logic prevException,
	input logic exception
);
	int failCount = 0; // Assertion failures so far

	memStrobes: assert property (@(posedge clk) disable iff (!rst) !(dmRd && dmWr))
		else begin
			$error("Data memory read and write strobes are high together");
			failCount++;
		end

	// Register jumps and branches are a subset of all control transfers
	branchSubset: assert property (@(posedge clk) disable iff (!rst) branchOrJr |-> isBranch)
		else begin
			$error("branchOrJr is high without isBranch");
			failCount++;
		end

	mulDivWrites: assert property (@(posedge clk) disable iff (!rst) mulDivStart |-> hiloWr)
		else begin
			$error("Multiply or divide started without a HI/LO write");
			failCount++;
		end

	resetQuiet: assert property (@(posedge clk) (!rst && !prevException) |-> !exception)
		else begin
			$error("Exception raised while in reset");
			failCount++;
		end
endmodule

bind idControl idControl_asserts u_idControlAsserts (.*);

//--- hdl/branchUnit.sv
`timescale 1ns/1ns

module branchUnit import decodePkg::*; (
	instrFieldsIf.dec fields,
	input logic cmpEq,
	input signClassE cmpSign,
	output logic isBranch,
	output logic branchOrJr,
	output npcOpE npcOp
);
	typedef enum logic [2:0] {
		BC_NONE, BC_EQ, BC_NE, BC_GEZ, BC_LTZ, BC_LEZ, BC_GTZ
	} brCondE;

	typedef enum logic [1:0] {JK_NONE, JK_IMM, JK_REG} jumpKindE;

	brCondE brCond;
	jumpKindE jumpKind;
	logic taken;

	always_comb begin
		case (fields.op)
			OP_BEQ: brCond = BC_EQ;
			OP_BNE: brCond = BC_NE;
			OP_BLEZ: brCond = BC_LEZ;
			OP_BGTZ: brCond = BC_GTZ;
			OP_REGIMM: begin
				case (fields.rt)
					RI_BGEZ, RI_BGEZAL: brCond = BC_GEZ;
					RI_BLTZ, RI_BLTZAL: brCond = BC_LTZ;
					default: brCond = BC_NONE; // Unknown rt is not a branch
				endcase
			end
			default: brCond = BC_NONE;
		endcase
	end

	always_comb begin
		if (fields.op == OP_J || fields.op == OP_JAL)
			jumpKind = JK_IMM;
		else if (fields.op == OP_SPECIAL && fields.funct inside {FN_JR, FN_JALR})
			jumpKind = JK_REG;
		else
			jumpKind = JK_NONE;
	end

	// Comparator flags against the condition
	always_comb begin
		case (brCond)
			BC_EQ: taken = cmpEq;
			BC_NE: taken = !cmpEq;
			BC_GEZ: taken = (cmpSign != SIGN_NEG);
			BC_LTZ: taken = (cmpSign == SIGN_NEG);
			BC_LEZ: taken = (cmpSign != SIGN_POS);
			BC_GTZ: taken = (cmpSign == SIGN_POS);
			default: taken = 1'b0;
		endcase
	end

	assign isBranch = (brCond != BC_NONE) || (jumpKind != JK_NONE);
	assign branchOrJr = (brCond != BC_NONE) || (jumpKind == JK_REG);

	always_comb begin
		if (brCond != BC_NONE)
			npcOp = taken ? NPC_BRANCH : NPC_SEQ;
		else if (jumpKind == JK_IMM)
			npcOp = NPC_JUMP;
		else if (jumpKind == JK_REG)
			npcOp = NPC_REG;
		else
			npcOp = NPC_SEQ;
	end
endmodule

//--- hdl/decodePkg.sv
package decodePkg;

	localparam int OP_W = 6;
	localparam int FUNCT_W = 6;
	localparam int REG_W = 5;
	localparam int EXC_W = 5;

	typedef enum logic [OP_W-1:0] {
		OP_SPECIAL = 6'b000000,
		OP_REGIMM = 6'b000001,
		OP_J = 6'b000010,
		OP_JAL = 6'b000011,
		OP_BEQ = 6'b000100,
		OP_BNE = 6'b000101,
		OP_BLEZ = 6'b000110,
		OP_BGTZ = 6'b000111,
		OP_ADDI = 6'b001000,
		OP_ADDIU = 6'b001001,
		OP_SLTI = 6'b001010,
		OP_SLTIU = 6'b001011,
		OP_ANDI = 6'b001100,
		OP_ORI = 6'b001101,
		OP_XORI = 6'b001110,
		OP_LUI = 6'b001111,
		OP_COP0 = 6'b010000,
		OP_LB = 6'b100000,
		OP_LH = 6'b100001,
		OP_LW = 6'b100011,
		OP_LBU = 6'b100100,
		OP_LHU = 6'b100101,
		OP_SB = 6'b101000,
		OP_SH = 6'b101001,
		OP_SW = 6'b101011
	} opcodeE;

	typedef enum logic [FUNCT_W-1:0] {
		FN_SLL = 6'b000000,
		FN_SRL = 6'b000010,
		FN_SRA = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_JR = 6'b001000,
		FN_JALR = 6'b001001,
		FN_SYSCALL = 6'b001100,
		FN_BREAK = 6'b001101,
		FN_MFHI = 6'b010000,
		FN_MTHI = 6'b010001,
		FN_MFLO = 6'b010010,
		FN_MTLO = 6'b010011,
		FN_MULT = 6'b011000,
		FN_MULTU = 6'b011001,
		FN_DIV = 6'b011010,
		FN_DIVU = 6'b011011,
		FN_ADD = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND = 6'b100100,
		FN_OR = 6'b100101,
		FN_XOR = 6'b100110,
		FN_NOR = 6'b100111,
		FN_SLT = 6'b101010,
		FN_SLTU = 6'b101011
	} functE;

	// ERET lives under COP0 and reuses the MULT function code
	localparam functE FN_ERET = FN_MULT;

	typedef enum logic [REG_W-1:0] {
		RI_BLTZ = 5'b00000,
		RI_BGEZ = 5'b00001,
		RI_BLTZAL = 5'b10000,
		RI_BGEZAL = 5'b10001
	} regimmE;

	typedef enum logic [REG_W-1:0] {CP_MFC0 = 5'b00000, CP_MTC0 = 5'b00100} cop0RsE;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0, ALU_SUB = 4'd1, ALU_OR = 4'd2, ALU_AND = 4'd3,
		ALU_NOR = 4'd4, ALU_XOR = 4'd5, ALU_SLL = 4'd6, ALU_SRL = 4'd7,
		ALU_SRA = 4'd8, ALU_SLT = 4'd9, ALU_SLTU = 4'd10, ALU_ADDU = 4'd11,
		ALU_SUBU = 4'd12, ALU_NONE = 4'd15
	} aluOpE;

	typedef enum logic [1:0] {MD_MULTU, MD_MULT, MD_DIVU, MD_DIV} mulDivOpE;
	typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_UPPER} extOpE;
	typedef enum logic [2:0] {
		MEM_SB, MEM_SH, MEM_SW, MEM_LBU, MEM_LB, MEM_LHU, MEM_LH, MEM_LW
	} memSizeE;
	typedef enum logic [1:0] {HILO_LO, HILO_HI, HILO_BOTH} hiloWrSelE;
	typedef enum logic [1:0] {DEST_RT, DEST_RD, DEST_RA} destSelE;
	typedef enum logic [2:0] {
		WB_HILO, WB_IMM_UPPER, WB_ALU, WB_LINK, WB_MEM, WB_CP0
	} wbSrcE;
	typedef enum logic [1:0] {NPC_SEQ, NPC_BRANCH, NPC_JUMP, NPC_REG} npcOpE;
	typedef enum logic [1:0] {SIGN_ZERO, SIGN_POS, SIGN_NEG} signClassE;
	typedef enum logic [EXC_W-1:0] {
		EXC_NONE = 5'd0, EXC_SYS = 5'd8, EXC_BP = 5'd9, EXC_RI = 5'd10
	} excCodeE;

endpackage

//--- hdl/exceptionDecode.sv
`timescale 1ns/1ns

module exceptionDecode import decodePkg::*; (
	input logic clk,
	input logic rst,
	instrFieldsIf.dec fields,
	input logic rfWr,
	input logic hiloWr,
	input logic dmWr,
	input logic branchOrJr,
	input logic prevException,
	input logic [EXC_W-1:0] prevExcCode,
	input logic ifFlush,
	output logic exception,
	output logic [EXC_W-1:0] excCode,
	output logic eretFlush,
	output logic cp0Wr
);
	logic resetShadow;
	logic isBreak;
	logic isSyscall;
	logic legal;

	// High during reset and for the first cycle after it
	always_ff @(posedge clk) begin
		if (!rst)
			resetShadow <= 1'b1;
		else
			resetShadow <= 1'b0;
	end

	assign isBreak = (fields.op == OP_SPECIAL) && (fields.funct == FN_BREAK);
	assign isSyscall = (fields.op == OP_SPECIAL) && (fields.funct == FN_SYSCALL);
	assign legal = rfWr || hiloWr || dmWr || isBreak || isSyscall || branchOrJr ||
		(fields.op inside {OP_COP0, OP_J, OP_JAL});

	assign eretFlush = (fields.op == OP_COP0) && (fields.funct == FN_ERET);
	assign cp0Wr = (fields.op == OP_COP0) && (fields.rs == CP_MTC0);

	always_comb begin
		exception = 1'b1;
		if (prevException)
			excCode = prevExcCode; // Older stage wins
		else if (!legal && !resetShadow && !ifFlush)
			excCode = EXC_RI;
		else if (isBreak)
			excCode = EXC_BP;
		else if (isSyscall)
			excCode = EXC_SYS;
		else begin
			exception = 1'b0;
			excCode = EXC_NONE;
		end
	end
endmodule

//--- hdl/execDecode.sv
`timescale 1ns/1ns

module execDecode import decodePkg::*; (
	instrFieldsIf.dec fields,
	output aluOpE aluOp,
	output logic shamtSel,
	output extOpE extOp,
	output mulDivOpE mulDivOp,
	output logic mulDivStart,
	output logic hiloWr,
	output hiloWrSelE hiloWrSel,
	output logic hiloRdHi,
	output logic hiloAccess
);
	logic isSpecial;

	assign isSpecial = (fields.op == OP_SPECIAL);
	assign shamtSel = isSpecial && (fields.funct inside {FN_SLL, FN_SRL, FN_SRA});

	always_comb begin
		aluOp = ALU_NONE;
		case (fields.op)
			OP_SPECIAL: begin
				case (fields.funct)
					FN_ADD: aluOp = ALU_ADD;
					FN_ADDU: aluOp = ALU_ADDU;
					FN_SUB: aluOp = ALU_SUB;
					FN_SUBU: aluOp = ALU_SUBU;
					FN_OR: aluOp = ALU_OR;
					FN_AND: aluOp = ALU_AND;
					FN_NOR: aluOp = ALU_NOR;
					FN_XOR: aluOp = ALU_XOR;
					FN_SLL, FN_SLLV: aluOp = ALU_SLL; // Shift source picked by shamtSel
					FN_SRL, FN_SRLV: aluOp = ALU_SRL;
					FN_SRA, FN_SRAV: aluOp = ALU_SRA;
					FN_SLT: aluOp = ALU_SLT;
					FN_SLTU: aluOp = ALU_SLTU;
					default: aluOp = ALU_NONE;
				endcase
			end
			OP_ADDI: aluOp = ALU_ADD;
			OP_ADDIU: aluOp = ALU_ADDU;
			OP_ORI: aluOp = ALU_OR;
			OP_ANDI: aluOp = ALU_AND;
			OP_XORI: aluOp = ALU_XOR;
			OP_SLTI: aluOp = ALU_SLT;
			OP_SLTIU: aluOp = ALU_SLTU;
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW: aluOp = ALU_ADD; // Address
			default: aluOp = ALU_NONE;
		endcase
	end

	always_comb begin
		case (fields.op)
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: extOp = EXT_SIGN;
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW: extOp = EXT_SIGN;
			OP_LUI: extOp = EXT_UPPER;
			default: extOp = EXT_ZERO; // Logical immediates
		endcase
	end

	always_comb begin
		mulDivStart = 1'b0;
		hiloWr = 1'b0;
		hiloWrSel = HILO_LO;
		hiloRdHi = 1'b0;
		hiloAccess = 1'b0;
		if (isSpecial) begin
			case (fields.funct)
				FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
					mulDivStart = 1'b1;
					hiloWr = 1'b1;
					hiloWrSel = HILO_BOTH; // Result fills both halves
					hiloAccess = 1'b1;
				end
				FN_MTHI: begin
					hiloWr = 1'b1;
					hiloWrSel = HILO_HI;
					hiloAccess = 1'b1;
				end
				FN_MTLO: begin
					hiloWr = 1'b1;
					hiloAccess = 1'b1;
				end
				FN_MFHI: begin
					hiloRdHi = 1'b1;
					hiloAccess = 1'b1;
				end
				FN_MFLO: hiloAccess = 1'b1;
				default: hiloAccess = 1'b0;
			endcase
		end
	end

	always_comb begin
		case (fields.funct)
			FN_MULT: mulDivOp = MD_MULT;
			FN_DIVU: mulDivOp = MD_DIVU;
			FN_DIV: mulDivOp = MD_DIV;
			default: mulDivOp = MD_MULTU; // Ignored unless mulDivStart
		endcase
	end
endmodule

//--- hdl/idControl.sv
`timescale 1ns/1ns

module idControl import decodePkg::*; (
	input logic clk,
	input logic rst,
	input logic [OP_W-1:0] op,
	input logic [FUNCT_W-1:0] funct,
	input logic [REG_W-1:0] rs,
	input logic [REG_W-1:0] rt,
	input logic cmpEq,
	input logic [1:0] cmpSign,
	input logic prevException,
	input logic [EXC_W-1:0] prevExcCode,
	input logic ifFlush,
	output aluOpE aluOp,
	output logic shamtSel,
	output extOpE extOp,
	output mulDivOpE mulDivOp,
	output logic mulDivStart,
	output logic hiloWr,
	output hiloWrSelE hiloWrSel,
	output logic hiloRdHi,
	output logic hiloAccess,
	output logic dmRd,
	output logic dmWr,
	output memSizeE dmSize,
	output logic rfWr,
	output destSelE destSel,
	output wbSrcE wbSrc,
	output logic aluSrcImm,
	output logic cp0Rd,
	output logic isBranch,
	output logic branchOrJr,
	output npcOpE npcOp,
	output logic exception,
	output logic [EXC_W-1:0] excCode,
	output logic eretFlush,
	output logic cp0Wr
);
	instrFieldsIf fields ();

	// Source side of the field bundle
	assign fields.op = opcodeE'(op);
	assign fields.funct = functE'(funct);
	assign fields.rs = rs;
	assign fields.rt = rt;

	execDecode u_execDecode (
		.fields(fields.dec),
		.aluOp(aluOp),
		.shamtSel(shamtSel),
		.extOp(extOp),
		.mulDivOp(mulDivOp),
		.mulDivStart(mulDivStart),
		.hiloWr(hiloWr),
		.hiloWrSel(hiloWrSel),
		.hiloRdHi(hiloRdHi),
		.hiloAccess(hiloAccess)
	);

	memWbDecode u_memWbDecode (
		.fields(fields.dec),
		.dmRd(dmRd),
		.dmWr(dmWr),
		.dmSize(dmSize),
		.rfWr(rfWr),
		.destSel(destSel),
		.wbSrc(wbSrc),
		.aluSrcImm(aluSrcImm),
		.cp0Rd(cp0Rd)
	);

	branchUnit u_branchUnit (
		.fields(fields.dec),
		.cmpEq(cmpEq),
		.cmpSign(signClassE'(cmpSign)),
		.isBranch(isBranch),
		.branchOrJr(branchOrJr),
		.npcOp(npcOp)
	);

	exceptionDecode u_exceptionDecode (
		.clk(clk),
		.rst(rst),
		.fields(fields.dec),
		.rfWr(rfWr),
		.hiloWr(hiloWr),
		.dmWr(dmWr),
		.branchOrJr(branchOrJr),
		.prevException(prevException),
		.prevExcCode(prevExcCode),
		.ifFlush(ifFlush),
		.exception(exception),
		.excCode(excCode),
		.eretFlush(eretFlush),
		.cp0Wr(cp0Wr)
	);
endmodule

//--- hdl/instrFieldsIf.sv
`timescale 1ns/1ns

interface instrFieldsIf import decodePkg::*; ();
	opcodeE op;
	functE funct;
	logic [REG_W-1:0] rs;
	logic [REG_W-1:0] rt; // Also the REGIMM branch selector

	modport src (
		output op,
		output funct,
		output rs,
		output rt
	);

	modport dec (
		input op,
		input funct,
		input rs,
		input rt
	);
endinterface

//--- hdl/memWbDecode.sv
`timescale 1ns/1ns

module memWbDecode import decodePkg::*; (
	instrFieldsIf.dec fields,
	output logic dmRd,
	output logic dmWr,
	output memSizeE dmSize,
	output logic rfWr,
	output destSelE destSel,
	output wbSrcE wbSrc,
	output logic aluSrcImm,
	output logic cp0Rd
);
	logic isLoad;
	logic isLinkRegimm;

	assign isLoad = fields.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	assign isLinkRegimm = (fields.op == OP_REGIMM) &&
		(fields.rt inside {RI_BLTZAL, RI_BGEZAL});

	assign dmRd = isLoad;
	assign dmWr = fields.op inside {OP_SB, OP_SH, OP_SW};
	assign cp0Rd = (fields.op == OP_COP0) && (fields.rs == CP_MFC0);
	assign aluSrcImm = (fields.op != OP_SPECIAL); // Second operand from the immediate

	always_comb begin
		case (fields.op)
			OP_SB: dmSize = MEM_SB;
			OP_SH: dmSize = MEM_SH;
			OP_SW: dmSize = MEM_SW;
			OP_LBU: dmSize = MEM_LBU;
			OP_LB: dmSize = MEM_LB;
			OP_LHU: dmSize = MEM_LHU;
			OP_LH: dmSize = MEM_LH;
			default: dmSize = MEM_LW;
		endcase
	end

	always_comb begin
		case (fields.op)
			OP_SPECIAL: rfWr = fields.funct inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
				FN_OR, FN_AND, FN_NOR, FN_XOR, FN_SLL, FN_SLLV, FN_SRL, FN_SRLV,
				FN_SRA, FN_SRAV, FN_SLT, FN_SLTU, FN_JALR, FN_MFHI, FN_MFLO};
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: rfWr = 1'b1;
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: rfWr = 1'b1;
			OP_REGIMM: rfWr = isLinkRegimm;
			OP_JAL: rfWr = 1'b1;
			OP_COP0: rfWr = cp0Rd;
			default: rfWr = isLoad;
		endcase
	end

	always_comb begin
		case (fields.op)
			OP_SPECIAL: destSel = DEST_RD;
			OP_REGIMM, OP_JAL: destSel = DEST_RA; // Links go to r31
			default: destSel = DEST_RT;
		endcase
	end

	always_comb begin
		wbSrc = WB_ALU;
		case (fields.op)
			OP_SPECIAL: begin
				if (fields.funct inside {FN_MFHI, FN_MFLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU})
					wbSrc = WB_HILO;
				else if (fields.funct == FN_JALR)
					wbSrc = WB_LINK;
			end
			OP_REGIMM, OP_JAL: wbSrc = WB_LINK;
			OP_LUI: wbSrc = WB_IMM_UPPER;
			OP_COP0: wbSrc = cp0Rd ? WB_CP0 : WB_ALU;
			default: wbSrc = isLoad ? WB_MEM : WB_ALU;
		endcase
	end
endmodule

//--- idControl.f
hdl/decodePkg.sv
hdl/instrFieldsIf.sv
hdl/execDecode.sv
hdl/memWbDecode.sv
hdl/branchUnit.sv
hdl/exceptionDecode.sv
hdl/idControl.sv
dv/idControl_asserts.sv
dv/idControlTb.sv

//--- run.sh
#!/bin/sh
set -e

verilator --binary --assert -j 0 --top-module idControlTb -Mdir obj_dir -f idControl.f
./obj_dir/VidControlTb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "^=== PASS ===$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
